// ==== source/mul_pkg.sv ====
package mul_pkg;

    ////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////

    // operand width of each requester
    localparam int mul_width = 64;

    // full double-width product
    localparam int prod_width = 2 * mul_width;

    // booth working adder, product plus guard bits
    localparam int ext_width = prod_width + 4;

    // multiplier shift register, two sign bits on top and a zero below
    localparam int mplr_width = mul_width + 3;

    ////////////////////////////////////////
    // sharing and iteration control
    ////////////////////////////////////////

    // requester ports on the shared multiplier
    localparam int num_ports = 2;
    localparam int port_bits = $clog2(num_ports);

    // iteration counter, wide enough to reach the limit
    localparam int cnt_width = 6;

    // hard finish after this many booth steps
    localparam logic [cnt_width-1:0] max_iter = 6'd32;

endpackage

// ==== source/radix4_unit.sv ====
module radix4_unit (
    input  logic [2:0]                    booth,
    input  logic [mul_pkg::ext_width-1:0] multiplicand,
    output logic [mul_pkg::ext_width-1:0] partial_sum,
    output logic                          partial_c
);

    // twice the multiplicand, one place to the left
    logic [mul_pkg::ext_width-1:0] mcand_x2;

    assign mcand_x2 = {multiplicand[mul_pkg::ext_width-2:0], 1'b0};

    // booth triple {b(2i+1), b(2i), b(2i-1)}
    always_comb begin
        partial_sum = '0;
        partial_c   = 1'b0;
        unique case (booth)
            // run of zeros or run of ones
            3'b000, 3'b111: begin
                partial_sum = '0;
                partial_c   = 1'b0;
            end
            // +m
            3'b001, 3'b010: begin
                partial_sum = multiplicand;
                partial_c   = 1'b0;
            end
            // +2m
            3'b011: begin
                partial_sum = mcand_x2;
                partial_c   = 1'b0;
            end
            // -2m, inverted here, the +1 goes in as adder carry
            3'b100: begin
                partial_sum = ~mcand_x2;
                partial_c   = 1'b1;
            end
            // -m
            3'b101, 3'b110: begin
                partial_sum = ~multiplicand;
                partial_c   = 1'b1;
            end
        endcase
    end

endmodule

// ==== source/booth_mul_serial.sv ====
module booth_mul_serial (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [mul_pkg::mul_width-1:0]  mul1,
    input  logic [mul_pkg::mul_width-1:0]  mul2,
    input  logic                           is_signed,
    input  logic                           mul_valid,
    output logic                           P_valid,
    output logic [mul_pkg::prod_width-1:0] P
);

    // sign extension bits, zero for unsigned operands
    logic sgn_ext1;
    logic sgn_ext2;

    // multiplier, consumed two bits per step
    logic [mul_pkg::mplr_width-1:0] mplr;
    // multiplicand, moves up two bits per step
    logic [mul_pkg::ext_width-1:0]  mcand;
    // running sum
    logic [mul_pkg::ext_width-1:0]  acc;

    logic [2:0]                     booth;
    logic [mul_pkg::ext_width-1:0]  partial_sum;
    logic                           partial_c;
    logic [mul_pkg::ext_width-1:0]  carry_word;
    logic [mul_pkg::ext_width-1:0]  sum;

    logic                           in_progress;
    logic [mul_pkg::cnt_width-1:0]  iter_cnt;
    logic                           early_done;
    logic                           last_iter;

    assign sgn_ext1 = mul1[mul_pkg::mul_width-1] & is_signed;
    assign sgn_ext2 = mul2[mul_pkg::mul_width-1] & is_signed;

    ////////////////////////////////////////
    // operand shift registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mul_valid) begin
            mplr  <= {{2{sgn_ext1}}, mul1, 1'b0};
            mcand <= {{(mul_pkg::ext_width - mul_pkg::mul_width){sgn_ext2}}, mul2};
            acc   <= '0;
        end else if (in_progress) begin
            // zeros shifted in on top, so the early test sees them drain
            mplr  <= {2'b00, mplr[mul_pkg::mplr_width-1:2]};
            mcand <= {mcand[mul_pkg::ext_width-3:0], 2'b00};
            acc   <= sum;
        end
    end

    ////////////////////////////////////////
    // partial product and adder
    ////////////////////////////////////////

    assign booth = mplr[2:0];

    radix4_unit u_radix4 (
        .booth        (booth),
        .multiplicand (mcand),
        .partial_sum  (partial_sum),
        .partial_c    (partial_c)
    );

    // carry completes the negation
    assign carry_word = {{(mul_pkg::ext_width-1){1'b0}}, partial_c};
    assign sum        = acc + partial_sum + carry_word;

    // low half of the current sum, valid with P_valid
    assign P = sum[mul_pkg::prod_width-1:0];

    ////////////////////////////////////////
    // progress and finish
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            in_progress <= 1'b0;
        end else if (mul_valid) begin
            in_progress <= 1'b1;
        end else if (P_valid) begin
            in_progress <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            iter_cnt <= '0;
        end else if (P_valid || !in_progress) begin
            iter_cnt <= '0;
        end else begin
            iter_cnt <= iter_cnt + 1'b1;
        end
    end

    // nothing left above the current triple
    assign early_done = ~|mplr[mul_pkg::mplr_width-1:1] & in_progress;
    assign last_iter  = (iter_cnt == mul_pkg::max_iter) & in_progress;
    assign P_valid    = early_done | last_iter;

endmodule

// ==== source/mul_arbiter.sv ====
module mul_arbiter (
    input  logic                           clk,
    input  logic                           rst,
    // requester side
    input  logic                           req_0,
    input  logic                           req_1,
    input  logic [mul_pkg::mul_width-1:0]  op_a_0,
    input  logic [mul_pkg::mul_width-1:0]  op_a_1,
    input  logic [mul_pkg::mul_width-1:0]  op_b_0,
    input  logic [mul_pkg::mul_width-1:0]  op_b_1,
    input  logic                           op_signed_0,
    input  logic                           op_signed_1,
    output logic                           grant_0,
    output logic                           grant_1,
    output logic                           done_0,
    output logic                           done_1,
    output logic [mul_pkg::prod_width-1:0] product,
    // multiplier side
    output logic                           mul_valid,
    output logic [mul_pkg::mul_width-1:0]  mul1,
    output logic [mul_pkg::mul_width-1:0]  mul2,
    output logic                           is_signed,
    input  logic                           P_valid,
    input  logic [mul_pkg::prod_width-1:0] P
);

    // multiplier in use
    logic                          busy_q;
    logic [mul_pkg::port_bits-1:0] owner;
    // port with priority on the next tie
    logic [mul_pkg::port_bits-1:0] ptr;
    logic [mul_pkg::port_bits-1:0] pick;
    logic                          any_req;

    assign any_req = req_0 | req_1;

    // pointed port first, else whoever asks
    always_comb begin
        if (ptr == '0) begin
            pick = req_0 ? '0 : '1;
        end else begin
            pick = req_1 ? '1 : '0;
        end
    end

    ////////////////////////////////////////
    // grant and ownership
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q    <= 1'b0;
            owner     <= '0;
            ptr       <= '0;
            grant_0   <= 1'b0;
            grant_1   <= 1'b0;
            mul_valid <= 1'b0;
        end else begin
            grant_0   <= 1'b0;
            grant_1   <= 1'b0;
            mul_valid <= 1'b0;
            if (!busy_q) begin
                if (any_req) begin
                    busy_q    <= 1'b1;
                    owner     <= pick;
                    grant_0   <= (pick == '0);
                    grant_1   <= (pick != '0);
                    mul_valid <= 1'b1;
                end
            end else if (P_valid) begin
                // release, other port goes first next time
                busy_q <= 1'b0;
                ptr    <= ~owner;
            end
        end
    end

    // operands of the chosen port, held through the multiply
    always_ff @(posedge clk) begin
        if (!busy_q && any_req) begin
            mul1      <= (pick == '0) ? op_a_0 : op_a_1;
            mul2      <= (pick == '0) ? op_b_0 : op_b_1;
            is_signed <= (pick == '0) ? op_signed_0 : op_signed_1;
        end
    end

    // result straight back to the owner
    assign done_0  = busy_q & P_valid & (owner == '0);
    assign done_1  = busy_q & P_valid & (owner != '0);
    assign product = P;

endmodule

// ==== source/mul_port.sv ====
module mul_port (
    input  logic                           clk,
    input  logic                           rst,
    // outside command side
    input  logic                           cmd_valid,
    input  logic [mul_pkg::mul_width-1:0]  cmd_a,
    input  logic [mul_pkg::mul_width-1:0]  cmd_b,
    input  logic                           cmd_signed,
    output logic                           busy,
    output logic                           result_valid,
    output logic [mul_pkg::prod_width-1:0] result,
    // arbiter side
    output logic                           req,
    output logic [mul_pkg::mul_width-1:0]  op_a,
    output logic [mul_pkg::mul_width-1:0]  op_b,
    output logic                           op_signed,
    input  logic                           grant,
    input  logic                           done,
    input  logic [mul_pkg::prod_width-1:0] product
);

    logic accept;

    // strobes while busy are dropped
    assign accept = cmd_valid & ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            req          <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= done;
            if (accept) begin
                busy <= 1'b1;
                req  <= 1'b1;
            end else begin
                // req falls once granted
                if (grant) begin
                    req <= 1'b0;
                end
                // busy stays up through the result pulse
                if (result_valid) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // command held stable while req is up
    always_ff @(posedge clk) begin
        if (accept) begin
            op_a      <= cmd_a;
            op_b      <= cmd_b;
            op_signed <= cmd_signed;
        end
    end

    // product kept until the next result
    always_ff @(posedge clk) begin
        if (done) begin
            result <= product;
        end
    end

endmodule

// ==== source/mul_unit_top.sv ====
module mul_unit_top (
    input  logic                           clk,
    input  logic                           rst,
    // port 0
    input  logic                           cmd_valid_0,
    input  logic [mul_pkg::mul_width-1:0]  cmd_a_0,
    input  logic [mul_pkg::mul_width-1:0]  cmd_b_0,
    input  logic                           cmd_signed_0,
    output logic                           busy_0,
    output logic                           result_valid_0,
    output logic [mul_pkg::prod_width-1:0] result_0,
    // port 1
    input  logic                           cmd_valid_1,
    input  logic [mul_pkg::mul_width-1:0]  cmd_a_1,
    input  logic [mul_pkg::mul_width-1:0]  cmd_b_1,
    input  logic                           cmd_signed_1,
    output logic                           busy_1,
    output logic                           result_valid_1,
    output logic [mul_pkg::prod_width-1:0] result_1
);

    ////////////////////////////////////////
    // port to arbiter
    ////////////////////////////////////////

    logic                           req_0;
    logic                           req_1;
    logic [mul_pkg::mul_width-1:0]  op_a_0;
    logic [mul_pkg::mul_width-1:0]  op_a_1;
    logic [mul_pkg::mul_width-1:0]  op_b_0;
    logic [mul_pkg::mul_width-1:0]  op_b_1;
    logic                           op_signed_0;
    logic                           op_signed_1;
    logic                           grant_0;
    logic                           grant_1;
    logic                           done_0;
    logic                           done_1;
    // shared return bus, qualified by done_k
    logic [mul_pkg::prod_width-1:0] product;

    ////////////////////////////////////////
    // arbiter to multiplier
    ////////////////////////////////////////

    logic                           mul_valid;
    logic [mul_pkg::mul_width-1:0]  mul1;
    logic [mul_pkg::mul_width-1:0]  mul2;
    logic                           is_signed;
    logic                           P_valid;
    logic [mul_pkg::prod_width-1:0] P;

    mul_port u_port_0 (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid_0),
        .cmd_a        (cmd_a_0),
        .cmd_b        (cmd_b_0),
        .cmd_signed   (cmd_signed_0),
        .busy         (busy_0),
        .result_valid (result_valid_0),
        .result       (result_0),
        .req          (req_0),
        .op_a         (op_a_0),
        .op_b         (op_b_0),
        .op_signed    (op_signed_0),
        .grant        (grant_0),
        .done         (done_0),
        .product      (product)
    );

    mul_port u_port_1 (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid_1),
        .cmd_a        (cmd_a_1),
        .cmd_b        (cmd_b_1),
        .cmd_signed   (cmd_signed_1),
        .busy         (busy_1),
        .result_valid (result_valid_1),
        .result       (result_1),
        .req          (req_1),
        .op_a         (op_a_1),
        .op_b         (op_b_1),
        .op_signed    (op_signed_1),
        .grant        (grant_1),
        .done         (done_1),
        .product      (product)
    );

    mul_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .req_0       (req_0),
        .req_1       (req_1),
        .op_a_0      (op_a_0),
        .op_a_1      (op_a_1),
        .op_b_0      (op_b_0),
        .op_b_1      (op_b_1),
        .op_signed_0 (op_signed_0),
        .op_signed_1 (op_signed_1),
        .grant_0     (grant_0),
        .grant_1     (grant_1),
        .done_0      (done_0),
        .done_1      (done_1),
        .product     (product),
        .mul_valid   (mul_valid),
        .mul1        (mul1),
        .mul2        (mul2),
        .is_signed   (is_signed),
        .P_valid     (P_valid),
        .P           (P)
    );

    booth_mul_serial u_booth (
        .clk       (clk),
        .rst       (rst),
        .mul1      (mul1),
        .mul2      (mul2),
        .is_signed (is_signed),
        .mul_valid (mul_valid),
        .P_valid   (P_valid),
        .P         (P)
    );

endmodule

// ==== bench/mul_unit_tb.sv ====
module mul_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // commands per test, sized for the timeout
    localparam int n_unsigned  = 7;
    localparam int n_signed    = 4;
    localparam int n_early     = 4;
    localparam int n_contend   = 2;
    localparam int n_fair      = 12;
    localparam int n_random    = 200;
    localparam int n_cmds      = n_unsigned + n_signed + n_early + n_contend + n_fair + n_random;
    // each command may also wait out one on the other port
    localparam int cycle_limit = 40 * 2 * n_cmds + 500;

    logic         clk;
    logic         rst;
    logic         cmd_valid_0;
    logic [63:0]  cmd_a_0;
    logic [63:0]  cmd_b_0;
    logic         cmd_signed_0;
    logic         busy_0;
    logic         result_valid_0;
    logic [127:0] result_0;
    logic         cmd_valid_1;
    logic [63:0]  cmd_a_1;
    logic [63:0]  cmd_b_1;
    logic         cmd_signed_1;
    logic         busy_1;
    logic         result_valid_1;
    logic [127:0] result_1;

    // expected products in issue order, one queue per port
    logic [127:0] q0[$];
    logic [127:0] q1[$];
    logic [127:0] head_0;
    logic [127:0] head_1;

    int          errors;
    int          results;
    int          base_errors;
    int          base_results;
    int          cycles;
    int          seed;
    string       test_name;
    // order check, 2 means no result yet
    logic        fair_mode;
    logic [1:0]  last_port;

    logic [63:0] rnd_a[n_random];
    logic [63:0] rnd_b[n_random];
    logic        rnd_s[n_random];
    int          rnd_gap[n_random];

    mul_unit_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////

    // both operands widened the same way, low 128 bits kept
    function automatic logic [127:0] expected_product(input logic [63:0] a,
                                                      input logic [63:0] b,
                                                      input logic sgn);
        logic [127:0] wa;
        logic [127:0] wb;
        if (sgn) begin
            wa = {{64{a[63]}}, a};
            wb = {{64{b[63]}}, b};
        end else begin
            wa = {64'd0, a};
            wb = {64'd0, b};
        end
        return wa * wb;
    endfunction

    function automatic void refresh_heads();
        head_0 = (q0.size() > 0) ? q0[0] : '0;
        head_1 = (q1.size() > 0) ? q1[0] : '0;
    endfunction

    // stimulus lands 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // waits out busy, then a one-cycle strobe on that port only
    task automatic issue(input int port, input logic [63:0] a, input logic [63:0] b,
                         input logic sgn);
        if (port == 0) begin
            while (busy_0) next_cycle();
            cmd_a_0      = a;
            cmd_b_0      = b;
            cmd_signed_0 = sgn;
            cmd_valid_0  = 1'b1;
            q0.push_back(expected_product(a, b, sgn));
        end else begin
            while (busy_1) next_cycle();
            cmd_a_1      = a;
            cmd_b_1      = b;
            cmd_signed_1 = sgn;
            cmd_valid_1  = 1'b1;
            q1.push_back(expected_product(a, b, sgn));
        end
        refresh_heads();
        next_cycle();
        if (port == 0) begin
            cmd_valid_0 = 1'b0;
        end else begin
            cmd_valid_1 = 1'b0;
        end
    endtask

    // both ports idle, every accepted command has returned
    task automatic drain();
        while (busy_0 || busy_1) next_cycle();
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        base_errors  = errors;
        base_results = results;
    endtask

    task automatic finish_test();
        drain();
        $display("%s: %0d results, %0d mismatches", test_name,
                 results - base_results, errors - base_errors);
    endtask

    // a lone command moves the pointer, then a tie from idle
    task automatic fair_round(input int round);
        issue(round % 2, 64'd1000 + 64'(round), 64'hfeed_0000_0000_0000 ^ 64'(round), 1'b0);
        drain();
        // pointed port must win the tie
        fork
            issue(0, 64'd2000 + 64'(round), 64'h0bad_f00d_0000_0000 ^ 64'(round), 1'(round));
            issue(1, 64'd3000 + 64'(round), 64'hfeed_0000_0000_0000 ^ 64'(round), 1'(round));
        join
        drain();
    endtask

    // even entries on port 0, odd ones on port 1
    task automatic run_random(input int port);
        for (int i = port; i < n_random; i += 2) begin
            repeat (rnd_gap[i]) next_cycle();
            issue(port, rnd_a[i], rnd_b[i], rnd_s[i]);
        end
    endtask

    ////////////////////////////////////////
    // result monitor and assertions
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst && result_valid_0) begin
            results++;
            last_port = 2'd0;
            if (q0.size() == 0) begin
                errors++;
                $display("port 0 returned a result with no command outstanding");
            end else begin
                void'(q0.pop_front());
            end
        end
        if (!rst && result_valid_1) begin
            results++;
            last_port = 2'd1;
            if (q1.size() == 0) begin
                errors++;
                $display("port 1 returned a result with no command outstanding");
            end else begin
                void'(q1.pop_front());
            end
        end
        refresh_heads();
    end

    result_check_0: assert property (@(posedge clk) disable iff (rst)
        result_valid_0 |-> result_0 == head_0)
        else begin
            errors++;
            $display("Fail %s port 0 expected %h actual %h", test_name,
                     $sampled(head_0), $sampled(result_0));
        end

    result_check_1: assert property (@(posedge clk) disable iff (rst)
        result_valid_1 |-> result_1 == head_1)
        else begin
            errors++;
            $display("Fail %s port 1 expected %h actual %h", test_name,
                     $sampled(head_1), $sampled(result_1));
        end

    reset_idle: assert property (@(posedge clk) $fell(rst) |-> !busy_0 && !busy_1)
        else begin
            errors++;
            $display("a port was busy right after reset");
        end

    pulse_0: assert property (@(posedge clk) disable iff (rst)
        result_valid_0 |=> !result_valid_0)
        else begin
            errors++;
            $display("result_valid_0 stayed high for more than one cycle");
        end

    pulse_1: assert property (@(posedge clk) disable iff (rst)
        result_valid_1 |=> !result_valid_1)
        else begin
            errors++;
            $display("result_valid_1 stayed high for more than one cycle");
        end

    // round robin, the same port never finishes twice in a row
    order_0: assert property (@(posedge clk) disable iff (rst)
        fair_mode && result_valid_0 |-> last_port != 2'd0)
        else begin
            errors++;
            $display("Fail %s expected port 1 actual port 0", test_name);
        end

    order_1: assert property (@(posedge clk) disable iff (rst)
        fair_mode && result_valid_1 |-> last_port != 2'd1)
        else begin
            errors++;
            $display("Fail %s expected port 0 actual port 1", test_name);
        end

    ////////////////////////////////////////
    // timeout
    ////////////////////////////////////////

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] r;
        rst          = 1'b1;
        cmd_valid_0  = 1'b0;
        cmd_a_0      = '0;
        cmd_b_0      = '0;
        cmd_signed_0 = 1'b0;
        cmd_valid_1  = 1'b0;
        cmd_a_1      = '0;
        cmd_b_1      = '0;
        cmd_signed_1 = 1'b0;
        errors       = 0;
        results      = 0;
        fair_mode    = 1'b0;
        last_port    = 2'd2;
        test_name    = "reset";
        seed         = 71639;
        refresh_heads();
        // operands drawn up front so both ports see a fixed sequence
        for (int i = 0; i < n_random; i++) begin
            rnd_a[i]   = {$random(seed), $random(seed)};
            rnd_b[i]   = {$random(seed), $random(seed)};
            r          = $random(seed);
            rnd_s[i]   = r[0];
            r          = $random(seed);
            rnd_gap[i] = int'(r[1:0]);
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("unsigned");
        issue(0, 64'd0, '1, 1'b0);
        issue(0, '1, 64'd0, 1'b0);
        issue(0, 64'd1, 64'h0123_4567_89ab_cdef, 1'b0);
        issue(0, 64'hfedc_ba98_7654_3210, 64'd1, 1'b0);
        issue(0, '1, '1, 1'b0);
        issue(0, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0);
        issue(0, 64'd1 << 17, 64'd1 << 40, 1'b0);
        finish_test();

        begin_test("signed");
        issue(1, 64'hffff_ffff_ffff_fffb, 64'h0123_4567_89ab_cdef, 1'b1);
        issue(1, 64'h8000_0000_0000_0001, 64'hffff_ffff_0000_0000, 1'b1);
        issue(1, 64'h8000_0000_0000_0000, '1, 1'b1);
        issue(1, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000, 1'b1);
        finish_test();

        // short multipliers, large multiplicands
        begin_test("early_finish");
        issue(0, 64'd3, 64'hdead_beef_cafe_f00d, 1'b0);
        issue(0, 64'd5, 64'hffff_ffff_ffff_fff1, 1'b0);
        issue(0, 64'd7, 64'h8765_4321_0fed_cba9, 1'b1);
        issue(0, 64'd1, 64'h8000_0000_0000_0000, 1'b1);
        finish_test();

        begin_test("contention");
        fork
            issue(0, 64'h1111_2222_3333_4444, 64'h0000_0000_0000_0abc, 1'b0);
            issue(1, 64'hffff_ffff_ffff_ff00, 64'h0000_0000_1234_5678, 1'b1);
        join
        finish_test();

        // lone port alternates so the order stays strict
        begin_test("fairness");
        last_port = 2'd2;
        fair_mode = 1'b1;
        for (int i = 0; i < n_fair / 3; i++) begin
            fair_round(i);
        end
        finish_test();
        fair_mode = 1'b0;

        begin_test("random");
        fork
            run_random(0);
            run_random(1);
        join
        finish_test();

        if (q0.size() != 0 || q1.size() != 0) begin
            errors++;
            $display("expected results were left in a queue at the end");
        end
        $display("%0d results checked, %0d failures", results, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
source/mul_pkg.sv
source/radix4_unit.sv
source/booth_mul_serial.sv
source/mul_arbiter.sv
source/mul_port.sv
source/mul_unit_top.sv
bench/mul_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the shared multiply unit testbench with Verilator and run it
set -u
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module mul_unit_tb -o mul_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mul_unit_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$log"; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation passed"
exit 0
